// File: Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module csr_tb -f project.f \
		-Mdir obj_dir -o csr_tb
	./obj_dir/csr_tb > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qF '*** PASSED ***' $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: project.f
+incdir+tests
rtl/csr_pkg.sv
rtl/trap_pkg.sv
rtl/csr_regfile.sv
rtl/trap_unit.sv
rtl/csr_top.sv
tests/csr_tb.sv

// File: rtl/csr_pkg.sv
`default_nettype none

package csr_pkg;

    typedef logic [13:0] csr_addr_t;

    localparam csr_addr_t CSR_CRMD   = 14'd0;
    localparam csr_addr_t CSR_PRMD   = 14'd1;
    localparam csr_addr_t CSR_EUEN   = 14'd2;
    localparam csr_addr_t CSR_ECTL   = 14'd4;
    localparam csr_addr_t CSR_ESTAT  = 14'd5;
    localparam csr_addr_t CSR_ERA    = 14'd6;
    localparam csr_addr_t CSR_BADV   = 14'd7;
    localparam csr_addr_t CSR_EENTRY = 14'd12;
    localparam csr_addr_t CSR_CPUID  = 14'd32;
    localparam csr_addr_t CSR_SAVE0  = 14'd48;
    localparam csr_addr_t CSR_SAVE1  = 14'd49;
    localparam csr_addr_t CSR_SAVE2  = 14'd50;
    localparam csr_addr_t CSR_SAVE3  = 14'd51;

    // software-writable bits per register
    localparam logic [31:0] MASK_CRMD   = 32'h0000_01ff;
    localparam logic [31:0] MASK_PRMD   = 32'h0000_0007;
    localparam logic [31:0] MASK_EUEN   = 32'h0000_0001;
    localparam logic [31:0] MASK_ECTL   = 32'h0000_1bff;  // 12:11 and 9:0
    localparam logic [31:0] MASK_ESTAT  = 32'h0000_0003;  // sw interrupt bits only
    localparam logic [31:0] MASK_ERA    = 32'hffff_ffff;
    localparam logic [31:0] MASK_BADV   = 32'hffff_ffff;
    localparam logic [31:0] MASK_EENTRY = 32'hffff_ffc0;
    localparam logic [31:0] MASK_CPUID  = 32'h0000_0000;
    localparam logic [31:0] MASK_SAVE   = 32'hffff_ffff;  // save0..save3

    localparam logic [31:0] CRMD_RESET = 32'h0000_0008;  // da set

    localparam int CRMD_PLV_LSB    = 0;
    localparam int CRMD_IE         = 2;
    localparam int PRMD_PPLV_LSB   = 0;
    localparam int PRMD_PIE        = 2;
    localparam int ESTAT_IS_LSB    = 2;
    localparam int ESTAT_ECODE_LSB = 16;
    localparam int ESTAT_ESUB_LSB  = 22;
    localparam int ECTL_LIE_LSB    = 0;

    typedef enum logic [1:0] {
        CSR_NONE,
        CSR_RD,
        CSR_WR,
        CSR_XCHG
    } csr_op_e;

    typedef struct packed {
        csr_op_e     op;
        csr_addr_t   addr;
        logic [31:0] wdata;
        logic [31:0] wmask;
    } csr_req_t;

    typedef struct packed {
        logic        crmd_ie;
        logic [9:0]  ectl_lie;
        logic [7:0]  estat_is;  // hw lines
        logic [31:0] eentry;
    } csr_view_t;

endpackage

`default_nettype wire

// File: rtl/csr_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module csr_regfile
    import csr_pkg::*;
    import trap_pkg::*;
(
    input  wire              clk,
    input  wire              rst_n,
    input  wire csr_req_t    csr_req_i,
    input  wire [7:0]        interrupt_i,
    input  wire trap_event_t trap_i,
    output logic [31:0]      rd_data_o,
    output csr_view_t        view_o,
    output logic [31:0]      era_o
);

    typedef struct packed {
        logic       crmd;
        logic       prmd;
        logic       euen;
        logic       ectl;
        logic       estat;
        logic       era;
        logic       badv;
        logic       eentry;
        logic [3:0] save;
    } csr_sel_t;

    logic [31:0]      crmd_q;
    logic [31:0]      prmd_q;
    logic [31:0]      euen_q;
    logic [31:0]      ectl_q;
    logic [31:0]      estat_q;
    logic [31:0]      era_q;
    logic [31:0]      badv_q;
    logic [31:0]      eentry_q;
    logic [3:0][31:0] save_q;

    csr_sel_t    wsel;      // one-hot
    logic        wr_en;
    logic [31:0] wr_bits;
    logic [31:0] rd_val;

    function automatic logic [31:0] merge(input logic [31:0] old_val,
                                          input logic [31:0] data,
                                          input logic [31:0] bits,
                                          input logic [31:0] mask);
        logic [31:0] hit;
        hit = bits & mask;
        return (old_val & ~hit) | (data & hit);
    endfunction

    assign wr_bits = (csr_req_i.op == CSR_XCHG) ? csr_req_i.wmask : '1;
    assign wr_en   = (csr_req_i.op == CSR_WR || csr_req_i.op == CSR_XCHG) &&
                     (trap_i.kind == TRAP_NONE);  // no write in a trap cycle

    always_comb begin
        wsel = '0;
        case (csr_req_i.addr)
            CSR_CRMD:   wsel.crmd    = 1'b1;
            CSR_PRMD:   wsel.prmd    = 1'b1;
            CSR_EUEN:   wsel.euen    = 1'b1;
            CSR_ECTL:   wsel.ectl    = 1'b1;
            CSR_ESTAT:  wsel.estat   = 1'b1;
            CSR_ERA:    wsel.era     = 1'b1;
            CSR_BADV:   wsel.badv    = 1'b1;
            CSR_EENTRY: wsel.eentry  = 1'b1;
            CSR_SAVE0:  wsel.save[0] = 1'b1;
            CSR_SAVE1:  wsel.save[1] = 1'b1;
            CSR_SAVE2:  wsel.save[2] = 1'b1;
            CSR_SAVE3:  wsel.save[3] = 1'b1;
            default:    ;
        endcase
    end

    always_comb begin
        case (csr_req_i.addr)
            CSR_CRMD:   rd_val = crmd_q;
            CSR_PRMD:   rd_val = prmd_q;
            CSR_EUEN:   rd_val = euen_q;
            CSR_ECTL:   rd_val = ectl_q;
            CSR_ESTAT:  rd_val = estat_q;
            CSR_ERA:    rd_val = era_q;
            CSR_BADV:   rd_val = badv_q;
            CSR_EENTRY: rd_val = eentry_q;
            CSR_CPUID:  rd_val = '0;  // read-only zero
            CSR_SAVE0:  rd_val = save_q[0];
            CSR_SAVE1:  rd_val = save_q[1];
            CSR_SAVE2:  rd_val = save_q[2];
            CSR_SAVE3:  rd_val = save_q[3];
            default:    rd_val = '0;
        endcase
    end

    assign rd_data_o = (csr_req_i.op == CSR_NONE) ? '0 : rd_val;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            crmd_q   <= CRMD_RESET;
            prmd_q   <= '0;
            euen_q   <= '0;
            ectl_q   <= '0;
            estat_q  <= '0;
            era_q    <= '0;
            badv_q   <= '0;
            eentry_q <= '0;
            save_q   <= '0;
        end else begin
            if (wr_en) begin
                if (wsel.crmd)   crmd_q   <= merge(crmd_q, csr_req_i.wdata, wr_bits, MASK_CRMD);
                if (wsel.prmd)   prmd_q   <= merge(prmd_q, csr_req_i.wdata, wr_bits, MASK_PRMD);
                if (wsel.euen)   euen_q   <= merge(euen_q, csr_req_i.wdata, wr_bits, MASK_EUEN);
                if (wsel.ectl)   ectl_q   <= merge(ectl_q, csr_req_i.wdata, wr_bits, MASK_ECTL);
                if (wsel.estat)  estat_q  <= merge(estat_q, csr_req_i.wdata, wr_bits, MASK_ESTAT);
                if (wsel.era)    era_q    <= merge(era_q, csr_req_i.wdata, wr_bits, MASK_ERA);
                if (wsel.badv)   badv_q   <= merge(badv_q, csr_req_i.wdata, wr_bits, MASK_BADV);
                if (wsel.eentry) eentry_q <= merge(eentry_q, csr_req_i.wdata, wr_bits,
                                                   MASK_EENTRY);
                for (int i = 0; i < 4; i++) begin
                    if (wsel.save[i]) begin
                        save_q[i] <= merge(save_q[i], csr_req_i.wdata, wr_bits, MASK_SAVE);
                    end
                end
            end
            estat_q[ESTAT_IS_LSB +: 8] <= interrupt_i;  // sampled every cycle
            case (trap_i.kind)
                TRAP_INT, TRAP_EXC: begin
                    prmd_q[PRMD_PPLV_LSB +: 2]    <= crmd_q[CRMD_PLV_LSB +: 2];
                    prmd_q[PRMD_PIE]              <= crmd_q[CRMD_IE];
                    crmd_q[CRMD_PLV_LSB +: 2]     <= 2'b00;  // enter plv0, masked
                    crmd_q[CRMD_IE]               <= 1'b0;
                    era_q                         <= trap_i.era;
                    estat_q[ESTAT_ECODE_LSB +: 6] <= trap_i.ecode;
                    estat_q[ESTAT_ESUB_LSB +: 9]  <= trap_i.esubcode;
                    if (trap_i.badv_we) begin
                        badv_q <= trap_i.badv;
                    end
                end
                TRAP_ERTN: begin
                    crmd_q[CRMD_PLV_LSB +: 2] <= prmd_q[PRMD_PPLV_LSB +: 2];
                    crmd_q[CRMD_IE]           <= prmd_q[PRMD_PIE];
                end
                default: ;
            endcase
        end
    end

    assign view_o.crmd_ie  = crmd_q[CRMD_IE];
    assign view_o.ectl_lie = ectl_q[ECTL_LIE_LSB +: 10];
    assign view_o.estat_is = estat_q[ESTAT_IS_LSB +: 8];
    assign view_o.eentry   = eentry_q;  // low bits held zero by the mask
    assign era_o           = era_q;

    a_cpuid_zero: assert property (@(posedge clk) disable iff (!rst_n)
        (csr_req_i.op != CSR_NONE && csr_req_i.addr == CSR_CPUID) |-> rd_data_o == '0)
        else $error("cpuid read back nonzero");

endmodule

`default_nettype wire

// File: rtl/csr_top.sv
`timescale 1ns/1ps
`default_nettype none

module csr_top
    import csr_pkg::*;
    import trap_pkg::*;
(
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire csr_req_t         csr_req_i,
    input  wire pipe_excp_t [1:0] excp_i,
    input  wire [7:0]             interrupt_i,
    output logic [31:0]           rd_data_o,
    output logic [1:0]            flush_o,
    output logic [31:0]           redirect_addr_o
);

    csr_view_t   view;
    logic [31:0] era;
    trap_event_t trap;  // fed back for the state update

    csr_regfile u_regfile (
        .clk         (clk),
        .rst_n       (rst_n),
        .csr_req_i   (csr_req_i),
        .interrupt_i (interrupt_i),
        .trap_i      (trap),
        .rd_data_o   (rd_data_o),
        .view_o      (view),
        .era_o       (era)
    );

    trap_unit u_trap (
        .clk             (clk),
        .rst_n           (rst_n),
        .excp_i          (excp_i),
        .view_i          (view),
        .era_i           (era),
        .trap_o          (trap),
        .flush_o         (flush_o),
        .redirect_addr_o (redirect_addr_o)
    );

endmodule

`default_nettype wire

// File: rtl/trap_pkg.sv
`default_nettype none

package trap_pkg;

    typedef enum logic [5:0] {
        INT = 6'h00,
        PIL = 6'h01,
        PIS = 6'h02,
        PIF = 6'h03,
        PME = 6'h04,
        PPI = 6'h07,
        ADE = 6'h08,
        ALE = 6'h09,
        SYS = 6'h0b,
        BRK = 6'h0c,
        INE = 6'h0d
    } ecode_e;

    typedef struct packed {
        logic        excp;
        logic        ertn;
        ecode_e      ecode;
        logic [8:0]  esubcode;
        logic [31:0] pc;
        logic [31:0] bad_va;
    } pipe_excp_t;

    typedef enum logic [1:0] {
        TRAP_NONE,
        TRAP_INT,
        TRAP_EXC,
        TRAP_ERTN
    } trap_kind_e;

    typedef struct packed {
        trap_kind_e  kind;
        ecode_e      ecode;
        logic [8:0]  esubcode;
        logic [31:0] era;
        logic        badv_we;
        logic [31:0] badv;
    } trap_event_t;

    // address-related exceptions record the faulting va
    function automatic logic ecode_sets_badv(input ecode_e code);
        return code inside {ADE, ALE, PIL, PIS, PIF, PME, PPI};
    endfunction

endpackage

`default_nettype wire

// File: rtl/trap_unit.sv
`timescale 1ns/1ps
`default_nettype none

module trap_unit
    import csr_pkg::*;
    import trap_pkg::*;
(
    input  wire                   clk,     // assertions only
    input  wire                   rst_n,
    input  wire pipe_excp_t [1:0] excp_i,  // [1] is the older pipe
    input  wire csr_view_t        view_i,
    input  wire [31:0]            era_i,
    output trap_event_t           trap_o,
    output logic [1:0]            flush_o,
    output logic [31:0]           redirect_addr_o
);

    logic int_pending;

    // lie[9:2] lines up with the hw lines in estat.is
    assign int_pending = view_i.crmd_ie && |(view_i.ectl_lie[9:2] & view_i.estat_is);

    always_comb begin
        logic taken;
        trap_o          = '0;
        flush_o         = 2'b00;
        redirect_addr_o = '0;
        taken           = 1'b0;

        if (int_pending) begin
            trap_o.kind     = TRAP_INT;
            trap_o.ecode    = INT;
            trap_o.era      = excp_i[1].pc;  // resume at the older instruction
            flush_o         = 2'b11;
            redirect_addr_o = view_i.eentry;
            taken           = 1'b1;
        end

        // older pipe first, exception before ertn
        for (int p = 1; p >= 0; p--) begin
            if (!taken && excp_i[p].excp) begin
                trap_o.kind     = TRAP_EXC;
                trap_o.ecode    = excp_i[p].ecode;
                trap_o.esubcode = excp_i[p].esubcode;
                trap_o.era      = excp_i[p].pc;
                trap_o.badv_we  = ecode_sets_badv(excp_i[p].ecode);
                trap_o.badv     = excp_i[p].bad_va;
                flush_o         = (p == 1) ? 2'b11 : 2'b01;
                redirect_addr_o = view_i.eentry;
                taken           = 1'b1;
            end else if (!taken && excp_i[p].ertn) begin
                trap_o.kind     = TRAP_ERTN;
                flush_o         = (p == 1) ? 2'b11 : 2'b01;
                redirect_addr_o = era_i;
                taken           = 1'b1;
            end
        end
    end

    a_flush_kind: assert property (@(posedge clk) disable iff (!rst_n)
        (flush_o != 2'b00) == (trap_o.kind != TRAP_NONE))
        else $error("flush and trap kind disagree");

    a_one_event: assert property (@(posedge clk) disable iff (!rst_n)
        !(excp_i[1].excp && excp_i[1].ertn) && !(excp_i[0].excp && excp_i[0].ertn))
        else $error("pipe raised excp and ertn together");

endmodule

`default_nettype wire

// File: tests/csr_model.svh
`ifndef CSR_MODEL_SVH
`define CSR_MODEL_SVH

localparam int NREG = 13;

// register image follows this order
localparam csr_addr_t KEPT_ADDRS [NREG] = '{
    CSR_CRMD, CSR_PRMD, CSR_EUEN, CSR_ECTL, CSR_ESTAT, CSR_ERA, CSR_BADV,
    CSR_EENTRY, CSR_CPUID, CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3
};

logic [31:0] csr_image [NREG];

function automatic int reg_index(input csr_addr_t addr);
    for (int i = 0; i < NREG; i++) begin
        if (KEPT_ADDRS[i] == addr) begin
            return i;
        end
    end
    return -1;  // unknown number
endfunction

function automatic logic [31:0] writable_bits(input int idx);
    case (idx)
        0:       return 32'h0000_01ff;  // crmd
        1:       return 32'h0000_0007;  // prmd
        2:       return 32'h0000_0001;  // euen
        3:       return 32'h0000_1bff;  // ectl
        4:       return 32'h0000_0003;  // is and codes are hw-owned
        7:       return 32'hffff_ffc0;  // eentry
        8:       return 32'h0000_0000;  // cpuid
        default: return 32'hffff_ffff;
    endcase
endfunction

function automatic void reset_state();
    foreach (csr_image[i]) begin
        csr_image[i] = '0;
    end
    csr_image[0] = 32'h0000_0008;  // da only
endfunction

function automatic logic [31:0] expected_read(input csr_req_t req);
    int idx;
    idx = reg_index(req.addr);
    if (req.op == CSR_NONE || idx < 0) begin
        return '0;
    end
    return csr_image[idx];
endfunction

function automatic logic records_badv(input ecode_e code);
    case (code)
        PIL, PIS, PIF, PME, PPI, ADE, ALE: return 1'b1;
        default:                           return 1'b0;
    endcase
endfunction

function automatic trap_event_t pipe_event(input pipe_excp_t p);
    trap_event_t ev;
    ev = '0;
    if (p.excp) begin
        ev.kind     = TRAP_EXC;
        ev.ecode    = p.ecode;
        ev.esubcode = p.esubcode;
        ev.era      = p.pc;
        ev.badv_we  = records_badv(p.ecode);
        ev.badv     = p.bad_va;
    end else if (p.ertn) begin
        ev.kind = TRAP_ERTN;
    end
    return ev;
endfunction

function automatic trap_event_t select_event(input pipe_excp_t [1:0] ex);
    trap_event_t ev;
    ev = '0;
    // ie, then lie and the sampled lines share bits 9:2
    if (csr_image[0][2] && (csr_image[3][9:2] & csr_image[4][9:2]) != 8'h00) begin
        ev.kind  = TRAP_INT;
        ev.ecode = INT;
        ev.era   = ex[1].pc;
    end else if (ex[1].excp || ex[1].ertn) begin
        ev = pipe_event(ex[1]);
    end else begin
        ev = pipe_event(ex[0]);
    end
    return ev;
endfunction

function automatic logic [1:0] expected_flush(input trap_event_t ev,
                                              input pipe_excp_t [1:0] ex);
    if (ev.kind == TRAP_NONE) begin
        return 2'b00;
    end
    if (ev.kind == TRAP_INT || ex[1].excp || ex[1].ertn) begin
        return 2'b11;
    end
    return 2'b01;
endfunction

function automatic logic [31:0] expected_redirect(input trap_event_t ev);
    return (ev.kind == TRAP_ERTN) ? csr_image[5] : csr_image[7];
endfunction

function automatic void apply_edge(input csr_req_t req, input pipe_excp_t [1:0] ex,
                                   input logic [7:0] irq);
    trap_event_t ev;
    logic [31:0] crmd_old;
    logic [31:0] prmd_old;
    logic [31:0] bits;
    int          idx;
    ev       = select_event(ex);
    idx      = reg_index(req.addr);
    crmd_old = csr_image[0];
    prmd_old = csr_image[1];
    if (ev.kind == TRAP_NONE && idx >= 0 && (req.op == CSR_WR || req.op == CSR_XCHG)) begin
        bits = writable_bits(idx);
        if (req.op == CSR_XCHG) begin
            bits = bits & req.wmask;
        end
        csr_image[idx] = (csr_image[idx] & ~bits) | (req.wdata & bits);
    end
    csr_image[4][9:2] = irq;
    if (ev.kind == TRAP_INT || ev.kind == TRAP_EXC) begin
        csr_image[1][2:0]   = crmd_old[2:0];
        csr_image[0][2:0]   = 3'b000;
        csr_image[5]        = ev.era;
        csr_image[4][21:16] = ev.ecode;
        csr_image[4][30:22] = ev.esubcode;
        if (ev.badv_we) begin
            csr_image[6] = ev.badv;
        end
    end else if (ev.kind == TRAP_ERTN) begin
        csr_image[0][2:0] = prmd_old[2:0];  // plv and ie back
    end
endfunction

`endif

// File: tests/csr_tb.sv
`timescale 1ns/1ps
`default_nettype none

module csr_tb
    import csr_pkg::*;
    import trap_pkg::*;
();

    localparam logic [31:0] SEED = 32'h595b_18e3;
    localparam int RESET_CYCLES  = 4;
    localparam int N_DIRECTED    = 15;  // reset reads plus an idle cycle
    localparam int N_RANDOM      = 3000;
    localparam int LIMIT         = 2 * (N_DIRECTED + N_RANDOM) + RESET_CYCLES;

    logic             clk;
    logic             rst_n;
    csr_req_t         csr_req;
    pipe_excp_t [1:0] excp;
    logic [7:0]       irq;
    logic [31:0]      rd_data;
    logic [1:0]       flush;
    logic [31:0]      redirect_addr;
    int               errors;
    int               checks;
    int               cycles;

    `include "csr_model.svh"

    localparam ecode_e ECODES [10] = '{PIL, PIS, PIF, PME, PPI, ADE, ALE, SYS, BRK, INE};
    localparam csr_op_e OPS [4] = '{CSR_NONE, CSR_RD, CSR_WR, CSR_XCHG};

    csr_top dut0 (
        .clk             (clk),
        .rst_n           (rst_n),
        .csr_req_i       (csr_req),
        .excp_i          (excp),
        .interrupt_i     (irq),
        .rd_data_o       (rd_data),
        .flush_o         (flush),
        .redirect_addr_o (redirect_addr)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > LIMIT) begin
            $display("timeout, run went past %0d cycles", LIMIT);
            $display("*** FAILED ***");
            $finish;
        end
    end

    task automatic compare(input logic [31:0] got, input logic [31:0] exp, input string name);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic drive_quiet(input csr_op_e op, input csr_addr_t addr);
        csr_req      = '0;
        csr_req.op   = op;
        csr_req.addr = addr;
        excp         = '0;
        irq          = 8'h00;
    endtask

    task automatic drive_random();
        int sel;
        int kind;
        sel           = $urandom_range(NREG);  // NREG picks an unknown number
        csr_req.op    = OPS[2'($urandom_range(3))];
        csr_req.addr  = (sel == NREG) ? 14'($urandom_range(16383, 52)) : KEPT_ADDRS[sel];
        csr_req.wdata = $urandom();
        csr_req.wmask = $urandom();
        irq           = 8'($urandom());
        for (int p = 0; p < 2; p++) begin
            kind             = $urandom_range(15);
            excp[p].excp     = (kind == 0);
            excp[p].ertn     = (kind == 1);
            excp[p].ecode    = ECODES[4'($urandom_range(9))];
            excp[p].esubcode = 9'($urandom());
            excp[p].pc       = $urandom();
            excp[p].bad_va   = $urandom();
        end
    endtask

    // called just after a falling edge, returns at the next one
    task automatic run_cycle();
        trap_event_t ev;
        #1;
        ev = select_event(excp);
        compare(rd_data, expected_read(csr_req), "rd_data_o");
        compare({30'b0, flush}, {30'b0, expected_flush(ev, excp)}, "flush_o");
        if (ev.kind != TRAP_NONE) begin
            compare(redirect_addr, expected_redirect(ev), "redirect_addr_o");
        end
        @(posedge clk);
        apply_edge(csr_req, excp, irq);
        @(negedge clk);
    endtask

    initial begin
        clk    = 1'b0;
        rst_n  = 1'b0;
        errors = 0;
        checks = 0;
        cycles = 0;
        void'($urandom(SEED));
        drive_quiet(CSR_NONE, CSR_CRMD);
        reset_state();
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;

        for (int i = 0; i < NREG; i++) begin
            drive_quiet(CSR_RD, KEPT_ADDRS[i]);
            run_cycle();
        end
        drive_quiet(CSR_RD, 14'h0003);  // hole in the map
        run_cycle();
        drive_quiet(CSR_NONE, CSR_ERA);
        run_cycle();

        repeat (N_RANDOM) begin
            drive_random();
            run_cycle();
        end

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
